//--- src/l2_pkg.sv
/*
 * Shared definitions for the four-way L2 cache
 *   cache geometry and address field positions
 *   CPU request, memory request and tag lookup structs
 *   controller state encoding
 */

package l2_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int NUM_WAYS       = 4;
    localparam int WAY_BITS       = 2;
    localparam int NUM_SETS       = 16;
    localparam int INDEX_BITS     = 4;
    localparam int OFFSET_BITS    = 6;                          // 64-byte line
    localparam int WORD_BITS      = 128;
    localparam int LINE_BITS      = 512;
    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;
    localparam int WORD_SEL_BITS  = 2;
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int LINE_ADDR_BITS = TAG_BITS + INDEX_BITS;      // tag then index
    localparam int PLRU_BITS      = 3;                          // tree for 4 ways

    // address field positions
    localparam int WORD_LSB  = OFFSET_BITS - WORD_SEL_BITS;     // bits 5..4
    localparam int INDEX_LSB = OFFSET_BITS;                     // bits 9..6
    localparam int TAG_LSB   = OFFSET_BITS + INDEX_BITS;        // bits 31..10

    typedef struct packed {
        logic                  write;
        logic [ADDR_BITS-1:0]  addr;
        logic [WORD_BITS-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                      write;
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic [LINE_BITS-1:0]      wline;                      // unused on reads
    } mem_req_t;

    typedef struct packed {
        logic                              hit;
        logic [WAY_BITS-1:0]               hit_way;
        logic [NUM_WAYS-1:0]               valid;
        logic [NUM_WAYS-1:0]               dirty;
        logic [NUM_WAYS-1:0][TAG_BITS-1:0] tags;
    } lookup_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITE_BACK,
        FILL,
        UPDATE
    } l2_state_e;

endpackage

//--- src/l2_tag_lookup.sv
/*
 * Tag, valid and dirty arrays of the L2 cache
 *   synchronous read of all four ways of a set
 *   four-way tag compare against the request tag
 *   single-way write of tag, valid and dirty
 */

`timescale 1ns/100ps

module l2_tag_lookup
    import l2_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [INDEX_BITS-1:0] index,
    input  logic [TAG_BITS-1:0]   lookup_tag,
    input  logic                  tag_write,
    input  logic [WAY_BITS-1:0]   write_way,
    input  logic [TAG_BITS-1:0]   write_tag,
    input  logic                  write_dirty,
    output lookup_t               result
);

    logic [TAG_BITS-1:0]               tag_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]               valid_mem [NUM_SETS];
    logic [NUM_WAYS-1:0]               dirty_mem [NUM_SETS];
    logic [NUM_WAYS-1:0][TAG_BITS-1:0] tags_q;
    logic [NUM_WAYS-1:0]               valid_q;
    logic [NUM_WAYS-1:0]               dirty_q;
    logic [NUM_WAYS-1:0]               hit_vec;

    always_ff @(posedge clk) begin
        if (tag_write) begin
            tag_mem[index][write_way] <= write_tag;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            tags_q[w] <= tag_mem[index][w];                     // registered read
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (tag_write) begin
                valid_mem[index][write_way] <= 1'b1;
                dirty_mem[index][write_way] <= write_dirty;
            end
            valid_q <= valid_mem[index];
            dirty_q <= dirty_mem[index];
        end
    end

    always_comb begin
        result.hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && (tags_q[w] == lookup_tag);
        end
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                result.hit_way = WAY_BITS'(w);
            end
        end
        result.hit   = |hit_vec;
        result.valid = valid_q;
        result.dirty = dirty_q;
        result.tags  = tags_q;
    end

    // the controller only allocates on a miss, so a tag lives in one way at most
    a_single_hit: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(hit_vec));

endmodule

//--- src/l2_victim_select.sv
/*
 * Victim selection for the L2 cache
 *   per-set tree pseudo-LRU bits
 *   victim is the first invalid way, else the PLRU choice
 *   PLRU update on every touch of a way
 */

`timescale 1ns/100ps

module l2_victim_select
    import l2_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [INDEX_BITS-1:0] index,
    input  logic [NUM_WAYS-1:0]   valid_ways,
    input  logic                  plru_touch,
    input  logic [WAY_BITS-1:0]   touch_way,
    output logic [WAY_BITS-1:0]   victim_way
);

    logic [PLRU_BITS-1:0] plru_q [NUM_SETS];
    logic [PLRU_BITS-1:0] plru_set;
    logic [PLRU_BITS-1:0] plru_next;
    logic                 found_invalid;

    assign plru_set = plru_q[index];

    always_comb begin
        found_invalid = 1'b0;
        victim_way    = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!valid_ways[w] && !found_invalid) begin   // lowest invalid way
                found_invalid = 1'b1;
                victim_way    = WAY_BITS'(w);
            end
        end
        if (!found_invalid) begin
            if (!plru_set[0]) begin
                victim_way = plru_set[1] ? 2'd1 : 2'd0;     // lower half
            end else begin
                victim_way = plru_set[2] ? 2'd3 : 2'd2;     // upper half
            end
        end
    end

    always_comb begin
        plru_next = plru_set;
        if (!touch_way[1]) begin
            plru_next[0] = 1'b1;
            plru_next[1] = (touch_way == 2'd0);
        end else begin
            plru_next[0] = 1'b0;
            plru_next[2] = (touch_way == 2'd2);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (plru_touch) begin
            plru_q[index] <= plru_next;
        end
    end

    // the controller must stay quiet while the cache is held in reset
    a_no_touch_in_reset: assert property (@(posedge clk) !arst_n |-> !plru_touch);

endmodule

//--- src/l2_data_store.sv
/*
 * Line data arrays of the L2 cache
 *   four ways of 512-bit lines, read registered on the set index
 *   way and word selection on the read side
 *   full-line write into one way
 */

`timescale 1ns/100ps

module l2_data_store
    import l2_pkg::*;
(
    input  logic                     clk,
    input  logic [INDEX_BITS-1:0]    index,
    input  logic [WAY_BITS-1:0]      read_way,
    input  logic [WORD_SEL_BITS-1:0] word_sel,
    input  logic                     line_write,
    input  logic [WAY_BITS-1:0]      write_way,
    input  logic [LINE_BITS-1:0]     write_line,
    output logic [LINE_BITS-1:0]     way_line,
    output logic [WORD_BITS-1:0]     way_word
);

    logic [LINE_BITS-1:0]                       line_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][LINE_BITS-1:0]         lines_q;
    logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0]   words;

    always_ff @(posedge clk) begin
        if (line_write) begin
            line_mem[write_way][index] <= write_line;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            lines_q[w] <= line_mem[w][index];              // all four ways of the set
        end
    end

    assign way_line = lines_q[read_way];
    assign words    = way_line;
    assign way_word = words[word_sel];                      // word 0 at bits 127..0

endmodule

//--- src/l2_cache_ctrl.sv
/*
 * L2 cache controller
 *   request latch and CPU valid/ready handshakes
 *   FSM for hit, write-back and fill sequences
 *   write strobes for tag, line and PLRU state
 *   held memory request with done pulse
 */

`timescale 1ns/100ps

module l2_cache_ctrl
    import l2_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req_valid,
    input  cpu_req_t                 req,
    input  logic                     rsp_ready,
    input  logic                     mem_done,
    input  logic [LINE_BITS-1:0]     mem_rdata,
    input  lookup_t                  result,
    input  logic [WAY_BITS-1:0]      victim_way,
    input  logic [LINE_BITS-1:0]     way_line,
    input  logic [WORD_BITS-1:0]     way_word,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output logic [WORD_BITS-1:0]     rsp_data,
    output logic                     mem_req_valid,
    output mem_req_t                 mem_req,
    output logic [INDEX_BITS-1:0]    index,
    output logic [TAG_BITS-1:0]      lookup_tag,
    output logic                     tag_write,
    output logic [WAY_BITS-1:0]      write_way,
    output logic [TAG_BITS-1:0]      write_tag,
    output logic                     write_dirty,
    output logic                     plru_touch,
    output logic [WAY_BITS-1:0]      touch_way,
    output logic [WAY_BITS-1:0]      read_way,
    output logic [WORD_SEL_BITS-1:0] word_sel,
    output logic                     line_write,
    output logic [LINE_BITS-1:0]     write_line
);

    l2_state_e                                state_q;
    l2_state_e                                state_d;
    cpu_req_t                                 req_q;
    logic [WAY_BITS-1:0]                      victim_q;
    logic                                     victim_dirty;
    logic                                     write_hit;
    logic                                     fill_done;
    logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] merged_line;

    assign req_ready = (state_q == IDLE);
    assign rsp_valid = (state_q == RESPOND);

    // index goes straight from the port in IDLE so the arrays are read by LOOKUP
    assign index      = (state_q == IDLE) ? req.addr[INDEX_LSB +: INDEX_BITS]
                                          : req_q.addr[INDEX_LSB +: INDEX_BITS];
    assign lookup_tag = req_q.addr[TAG_LSB +: TAG_BITS];
    assign word_sel   = req_q.addr[WORD_LSB +: WORD_SEL_BITS];
    assign read_way   = result.hit ? result.hit_way : victim_way;

    assign victim_dirty = result.valid[victim_way] && result.dirty[victim_way];
    assign write_hit    = (state_q == LOOKUP) && result.hit && req_q.write;
    assign fill_done    = (state_q == FILL) && mem_req_valid && mem_done;

    always_comb begin
        merged_line           = way_line;
        merged_line[word_sel] = req_q.wdata;                // write word into hit line
    end

    assign tag_write   = write_hit || fill_done;
    assign line_write  = write_hit || fill_done;
    assign write_way   = fill_done ? victim_q : result.hit_way;
    assign write_tag   = lookup_tag;
    assign write_dirty = write_hit;                         // fills land clean
    assign write_line  = fill_done ? mem_rdata : merged_line;
    assign plru_touch  = (state_q == LOOKUP) && result.hit;
    assign touch_way   = result.hit_way;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (result.hit) begin
                    state_d = RESPOND;
                end else if (victim_dirty) begin
                    state_d = WRITE_BACK;
                end else begin
                    state_d = FILL;
                end
            end
            RESPOND: begin
                if (rsp_ready) begin
                    state_d = IDLE;
                end
            end
            WRITE_BACK: begin
                if (mem_req_valid && mem_done) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (fill_done) begin
                    state_d = UPDATE;
                end
            end
            UPDATE:  state_d = LOOKUP;                      // re-read the filled set
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= IDLE;
            mem_req_valid <= 1'b0;
        end else begin
            state_q <= state_d;
            if (mem_req_valid && mem_done) begin
                mem_req_valid <= 1'b0;                      // one idle cycle between requests
            end else if (state_q == LOOKUP && !result.hit && victim_dirty) begin
                mem_req_valid <= 1'b1;
            end else if (state_q == FILL && !mem_req_valid) begin
                mem_req_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (state_q == LOOKUP) begin
            victim_q <= victim_way;
            if (result.hit) begin
                rsp_data <= req_q.write ? req_q.wdata : way_word;
            end
        end
        if (state_q == LOOKUP && !result.hit && victim_dirty) begin
            mem_req <= '{write: 1'b1,
                         line_addr: {result.tags[victim_way],
                                     req_q.addr[INDEX_LSB +: INDEX_BITS]},
                         wline: way_line};              // old tag, same set
        end else if (state_q == FILL && !mem_req_valid) begin
            mem_req <= '{write: 1'b0,
                         line_addr: req_q.addr[ADDR_BITS-1 -: LINE_ADDR_BITS],
                         wline: '0};
        end
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)));

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req_valid && !mem_done) |=> (mem_req_valid && $stable(mem_req)));

endmodule

//--- src/l2_cache_top.sv
/*
 * L2 cache top level
 *   controller, tag lookup, victim selector and data store
 *   CPU request/response port and memory line port
 */

`timescale 1ns/100ps

module l2_cache_top
    import l2_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  cpu_req_t             req,
    input  logic                 rsp_ready,
    input  logic                 mem_done,
    input  logic [LINE_BITS-1:0] mem_rdata,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output logic [WORD_BITS-1:0] rsp_data,
    output logic                 mem_req_valid,
    output mem_req_t             mem_req
);

    lookup_t                   result;
    logic [INDEX_BITS-1:0]     index;
    logic [TAG_BITS-1:0]       lookup_tag;
    logic                      tag_write;
    logic [WAY_BITS-1:0]       write_way;
    logic [TAG_BITS-1:0]       write_tag;
    logic                      write_dirty;
    logic                      plru_touch;
    logic [WAY_BITS-1:0]       touch_way;
    logic [WAY_BITS-1:0]       victim_way;
    logic [WAY_BITS-1:0]       read_way;
    logic [WORD_SEL_BITS-1:0]  word_sel;
    logic                      line_write;
    logic [LINE_BITS-1:0]      write_line;
    logic [LINE_BITS-1:0]      way_line;
    logic [WORD_BITS-1:0]      way_word;

    l2_tag_lookup l2_tag_lookup_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .index       (index),
        .lookup_tag  (lookup_tag),
        .tag_write   (tag_write),
        .write_way   (write_way),
        .write_tag   (write_tag),
        .write_dirty (write_dirty),
        .result      (result)
    );

    l2_victim_select l2_victim_select_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (index),
        .valid_ways (result.valid),         // same set as the tag lookup
        .plru_touch (plru_touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    l2_data_store l2_data_store_i (
        .clk        (clk),
        .index      (index),
        .read_way   (read_way),
        .word_sel   (word_sel),
        .line_write (line_write),
        .write_way  (write_way),
        .write_line (write_line),
        .way_line   (way_line),
        .way_word   (way_word)
    );

    l2_cache_ctrl l2_cache_ctrl_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_ready     (rsp_ready),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata),
        .result        (result),
        .victim_way    (victim_way),
        .way_line      (way_line),
        .way_word      (way_word),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .index         (index),
        .lookup_tag    (lookup_tag),
        .tag_write     (tag_write),
        .write_way     (write_way),
        .write_tag     (write_tag),
        .write_dirty   (write_dirty),
        .plru_touch    (plru_touch),
        .touch_way     (touch_way),
        .read_way      (read_way),
        .word_sel      (word_sel),
        .line_write    (line_write),
        .write_line    (write_line)
    );

endmodule

//--- sim/l2_mem_model.sv
/*
 * Behavioral line memory for the L2 cache testbench
 *   held request answered after a random 1 to 8 cycle delay
 *   unwritten lines read back as their line address repeated
 */

`timescale 1ns/100ps

module l2_mem_model
    import l2_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 mem_req_valid,
    input  mem_req_t             mem_req,
    output logic                 mem_done,
    output logic [LINE_BITS-1:0] mem_rdata
);

    logic [LINE_BITS-1:0] lines [logic [LINE_ADDR_BITS-1:0]];
    logic                 busy;
    int                   wait_cnt;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_done  <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            wait_cnt  <= 0;
        end else begin
            mem_done <= 1'b0;                                   // single-cycle pulse
            if (mem_req_valid && !busy && !mem_done) begin
                busy     <= 1'b1;
                wait_cnt <= int'($urandom_range(8, 1));
            end else if (busy && wait_cnt > 1) begin
                wait_cnt <= wait_cnt - 1;
            end else if (busy) begin
                busy     <= 1'b0;
                mem_done <= 1'b1;
                if (mem_req.write) begin
                    lines[mem_req.line_addr] = mem_req.wline;
                end else if (lines.exists(mem_req.line_addr)) begin
                    mem_rdata <= lines[mem_req.line_addr];
                end else begin
                    mem_rdata <= {16{32'(mem_req.line_addr)}};  // one copy per 32-bit lane
                end
            end
        end
    end

endmodule

//--- sim/l2_cache_tb.sv
/*
 * Testbench for the four-way L2 cache
 *   clock, reset and CPU request driver with random back-pressure
 *   reference model of tags, lines, valid, dirty and PLRU bits
 *   checks on responses, hit latency and memory traffic
 */

`timescale 1ns/100ps

module l2_cache_tb
    import l2_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 req_valid;
    cpu_req_t             req;
    logic                 rsp_ready = 1'b1;
    logic                 req_ready;
    logic                 rsp_valid;
    logic [WORD_BITS-1:0] rsp_data;
    logic                 mem_req_valid;
    mem_req_t             mem_req;
    logic                 mem_done;
    logic [LINE_BITS-1:0] mem_rdata;
    bit                   stall_enable;
    string                test_name;
    mem_req_t             mem_log [$];                          // seen on the memory port
    mem_req_t             expect_log [$];                       // predicted by the model

    logic [TAG_BITS-1:0]  ref_tag   [NUM_SETS][NUM_WAYS];
    logic [LINE_BITS-1:0] ref_line  [NUM_SETS][NUM_WAYS];
    bit                   ref_valid [NUM_SETS][NUM_WAYS];
    bit                   ref_dirty [NUM_SETS][NUM_WAYS];
    bit [PLRU_BITS-1:0]   ref_plru  [NUM_SETS];
    logic [LINE_BITS-1:0] ref_mem   [logic [LINE_ADDR_BITS-1:0]];

    l2_cache_top l2_cache_top_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_ready     (rsp_ready),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

    l2_mem_model l2_mem_model_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        rsp_ready <= stall_enable ? 1'($urandom_range(1, 0)) : 1'b1;
        if (mem_req_valid && mem_done) begin
            mem_log.push_back(mem_req);
        end
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string expected, input string actual);
        stop_run($sformatf("Error %s: expected %s, actual %s", test_name, expected, actual));
    endtask

    a_rsp_held: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
        else stop_run("rsp_valid or rsp_data changed while rsp_ready was low");

    a_no_accept_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> !req_ready)
        else stop_run("req_ready was high while a response was still pending");

    function automatic logic [ADDR_BITS-1:0] make_addr(input logic [TAG_BITS-1:0] tag,
            input logic [INDEX_BITS-1:0] set, input logic [WORD_SEL_BITS-1:0] word);
        return {tag, set, word, 4'b0000};
    endfunction

    function automatic logic [WORD_BITS-1:0] random_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // predicts response and memory traffic of one request and updates the model
    task automatic model_access(input cpu_req_t r, output logic [WORD_BITS-1:0] rsp);
        logic [TAG_BITS-1:0]       tag;
        logic [INDEX_BITS-1:0]     set;
        logic [LINE_ADDR_BITS-1:0] fill_addr;
        int                        sel;
        int                        way;
        tag       = r.addr[TAG_LSB +: TAG_BITS];
        set       = r.addr[INDEX_LSB +: INDEX_BITS];
        sel       = int'(r.addr[WORD_LSB +: WORD_SEL_BITS]);
        fill_addr = {tag, set};
        way       = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                way = w;
            end
        end
        if (way < 0) begin
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[set][w]) begin
                    way = w;                                    // lowest invalid wins
                end
            end
            if (way < 0) begin
                way = ref_plru[set][0] ? (ref_plru[set][2] ? 3 : 2)
                                       : (ref_plru[set][1] ? 1 : 0);
            end
            if (ref_valid[set][way] && ref_dirty[set][way]) begin
                ref_mem[{ref_tag[set][way], set}] = ref_line[set][way];
                expect_log.push_back(mem_req_t'{write: 1'b1,
                                                line_addr: {ref_tag[set][way], set},
                                                wline: ref_line[set][way]});
            end
            expect_log.push_back(mem_req_t'{write: 1'b0, line_addr: fill_addr, wline: '0});
            ref_line[set][way]  = ref_mem.exists(fill_addr) ? ref_mem[fill_addr]
                                                            : {16{32'(fill_addr)}};
            ref_tag[set][way]   = tag;
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = 1'b0;
        end
        if (way < 2) begin
            ref_plru[set][0] = 1'b1;
            ref_plru[set][1] = (way == 0);
        end else begin
            ref_plru[set][0] = 1'b0;
            ref_plru[set][2] = (way == 2);
        end
        if (r.write) begin
            ref_line[set][way][sel * WORD_BITS +: WORD_BITS] = r.wdata;
            ref_dirty[set][way] = 1'b1;
        end
        rsp = ref_line[set][way][sel * WORD_BITS +: WORD_BITS];
    endtask

    // hit_latency of zero skips the latency check
    task automatic run_request(input logic write, input logic [ADDR_BITS-1:0] addr,
                               input logic [WORD_BITS-1:0] wdata, input int hit_latency);
        cpu_req_t             r;
        logic [WORD_BITS-1:0] exp_rsp;
        mem_req_t             exp_op;
        mem_req_t             got_op;
        int                   cycles;
        int                   first_valid;
        r = '{write: write, addr: addr, wdata: wdata};
        model_access(r, exp_rsp);
        req       <= r;
        req_valid <= 1'b1;
        for (cycles = 0; cycles <= WAIT_LIMIT; cycles++) begin
            @(posedge clk);
            if (req_ready) break;
        end
        if (cycles > WAIT_LIMIT) begin
            stop_run("Timeout waiting for the cache to accept a request");
        end
        req_valid   <= 1'b0;
        first_valid = 0;
        for (cycles = 1; cycles <= WAIT_LIMIT; cycles++) begin
            @(posedge clk);
            if (rsp_valid && first_valid == 0) begin
                first_valid = cycles;
            end
            if (rsp_valid && rsp_ready) break;
        end
        if (cycles > WAIT_LIMIT) begin
            stop_run("Timeout waiting for a response from the cache");
        end
        assert (rsp_data == exp_rsp)
            else value_error($sformatf("%h", exp_rsp), $sformatf("%h", rsp_data));
        assert (hit_latency == 0 || first_valid == hit_latency)
            else value_error($sformatf("%0d cycles", hit_latency),
                             $sformatf("%0d cycles", first_valid));
        assert (mem_log.size() == expect_log.size())
            else value_error($sformatf("%0d memory requests", expect_log.size()),
                             $sformatf("%0d memory requests", mem_log.size()));
        while (expect_log.size() > 0) begin
            exp_op = expect_log.pop_front();
            got_op = mem_log.pop_front();
            assert (got_op == exp_op)
                else value_error($sformatf("%h", exp_op), $sformatf("%h", got_op));
        end
    endtask

    initial begin
        void'($urandom(23325));
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        stall_enable = 1'b0;
        test_name    = "reset";
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert ({req_ready, rsp_valid, mem_req_valid} == 3'b100)
            else value_error("100", $sformatf("%b", {req_ready, rsp_valid, mem_req_valid}));

        test_name = "read_miss";
        run_request(1'b0, make_addr(22'h100, 4'd3, 2'd1), '0, 0);
        test_name = "read_hit";
        run_request(1'b0, make_addr(22'h100, 4'd3, 2'd1), '0, 2);
        test_name = "write_hit";
        run_request(1'b1, make_addr(22'h100, 4'd3, 2'd2), random_word(), 2);
        run_request(1'b0, make_addr(22'h100, 4'd3, 2'd2), '0, 2);
        run_request(1'b0, make_addr(22'h100, 4'd3, 2'd0), '0, 2);  // neighbour word

        test_name = "dirty_evict";
        run_request(1'b1, make_addr(22'h200, 4'd5, 2'd3), random_word(), 0);
        for (int t = 1; t < 5; t++) begin
            run_request(1'b0, make_addr(TAG_BITS'(22'h200 + t), 4'd5, 2'd0), '0, 0);
        end
        run_request(1'b0, make_addr(22'h200, 4'd5, 2'd3), '0, 0);  // comes back from memory

        test_name = "plru_order";
        for (int i = 0; i < 24; i++) begin
            run_request(1'b1, make_addr(TAG_BITS'(22'h300 + $urandom_range(5, 0)), 4'd9,
                                        WORD_SEL_BITS'($urandom)), random_word(), 0);
        end

        test_name    = "backpressure";
        stall_enable <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            run_request(1'($urandom_range(1, 0)),
                        make_addr(TAG_BITS'(22'h400 + $urandom_range(7, 0)),
                                  INDEX_BITS'($urandom_range(3, 0)),
                                  WORD_SEL_BITS'($urandom)), random_word(), 0);
        end
        stall_enable <= 1'b0;

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- sources.f
src/l2_pkg.sv
src/l2_tag_lookup.sv
src/l2_victim_select.sv
src/l2_data_store.sv
src/l2_cache_ctrl.sv
src/l2_cache_top.sv
sim/l2_mem_model.sv
sim/l2_cache_tb.sv
